// File: rtl/four_bank_fifo_pkg.sv
`default_nettype none

// shared widths and types for the four-bank buffer
package four_bank_fifo_pkg;

    // bank count
    // the write pointer wraps at this value
    localparam int num_banks = 4;

    // one stored byte
    localparam int data_w = 8;

    // payload byte
    typedef logic [data_w-1:0] data_t;

    // bank index
    // used for rd_id and for the write pointer
    typedef logic [$clog2(num_banks)-1:0] bank_id_t;

    // one bit per bank
    // carries enables and flags
    typedef logic [num_banks-1:0] bank_mask_t;

    // which master wins the next conflict
    typedef enum logic {
        prio_m0 = 1'b0,
        prio_m1 = 1'b1
    } prio_t;

endpackage

`default_nettype wire

// File: rtl/bank_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// single byte-wide synchronous fifo bank
module bank_fifo
    import four_bank_fifo_pkg::*;
#(
    parameter int fifo_depth = 32
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  wr_en,
    input  wire logic  rd_en,
    input  wire data_t wr_data,
    output data_t      rd_data,
    output logic       full,
    output logic       empty
);

    // pointer addresses one slot
    localparam int ptr_w = $clog2(fifo_depth);
    // count has to reach fifo_depth itself
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam int last_idx = fifo_depth - 1;

    // storage, no reset
    data_t mem [fifo_depth];

    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;

    // qualified strobes
    logic do_wr;
    logic do_rd;

    // flags straight from occupancy
    assign full  = (count_q == cnt_w'(fifo_depth));
    assign empty = (count_q == '0);

    // bank protects itself as well
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // storage write
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data;
        end
    end

    // registered read data
    // holds last popped byte between reads
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_data <= mem[rd_ptr_q];
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                // wrap at the last slot, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == ptr_w'(last_idx)) ? '0 : wr_ptr_q + ptr_w'(1);
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(last_idx)) ? '0 : rd_ptr_q + ptr_w'(1);
            end
            // simultaneous push and pop leaves count alone
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + cnt_w'(1);
                2'b01:   count_q <= count_q - cnt_w'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // the arbiter must already have qualified by our flags
    a_no_wr_when_full: assert property (
        @(posedge clk) disable iff (rst) !(wr_en && full)
    ) else $error("write strobe while bank full");

    a_no_rd_when_empty: assert property (
        @(posedge clk) disable iff (rst) !(rd_en && empty)
    ) else $error("read strobe while bank empty");

endmodule

`default_nettype wire

// File: rtl/port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

// two-master arbiter
// alternating priority, round-robin write bank, addressed reads
module port_arbiter
    import four_bank_fifo_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       wr_en_m0,
    input  wire logic       rd_en_m0,
    input  wire logic       wr_en_m1,
    input  wire logic       rd_en_m1,
    input  wire data_t      data_in_m0,
    input  wire data_t      data_in_m1,
    input  wire bank_id_t   rd_id_m0,
    input  wire bank_id_t   rd_id_m1,
    input  wire bank_mask_t bank_full,
    input  wire bank_mask_t bank_empty,
    output bank_mask_t      bank_wr_en,
    output bank_mask_t      bank_rd_en,
    output data_t           wr_data,
    output logic            rd_grant_m0,
    output logic            rd_grant_m1
);

    // who wins the next conflict
    prio_t prio_q;

    // next bank to receive a write
    bank_id_t wr_ptr_q;

    // raw requests
    logic req_m0;
    logic req_m1;

    // one winner at most
    logic grant_m0;
    logic grant_m1;

    // winner's strobes
    logic     wr_go;
    logic     rd_go;
    bank_id_t rd_id;

    // strobes after bank flag check
    logic wr_ok;
    logic rd_ok;

    // a master requests on either strobe
    assign req_m0 = wr_en_m0 || rd_en_m0;
    assign req_m1 = wr_en_m1 || rd_en_m1;

    // lone requester always wins
    // on conflict the priority register decides
    assign grant_m0 = req_m0 && (!req_m1 || (prio_q == prio_m0));
    assign grant_m1 = req_m1 && (!req_m0 || (prio_q == prio_m1));

    // winner may write and read in the same cycle
    // loser's strobes just fall away here
    assign wr_go = (grant_m0 && wr_en_m0) || (grant_m1 && wr_en_m1);
    assign rd_go = (grant_m0 && rd_en_m0) || (grant_m1 && rd_en_m1);

    // bank id and payload of the winner
    assign rd_id   = grant_m1 ? rd_id_m1 : rd_id_m0;
    assign wr_data = grant_m1 ? data_in_m1 : data_in_m0;

    // write target is fixed by the pointer
    assign wr_ok = wr_go && !bank_full[wr_ptr_q];
    // read target is chosen by the master
    assign rd_ok = rd_go && !bank_empty[rd_id];

    // single-bank enables
    always_comb begin
        bank_wr_en = '0;
        bank_rd_en = '0;
        if (wr_ok) begin
            bank_wr_en = bank_mask_t'(1) << wr_ptr_q;
        end
        if (rd_ok) begin
            bank_rd_en = bank_mask_t'(1) << rd_id;
        end
    end

    // read grants to the return path
    // empty-bank reads give no grant and no valid later
    assign rd_grant_m0 = rd_ok && grant_m0;
    assign rd_grant_m1 = rd_ok && grant_m1;

    // priority update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio_q <= prio_m0;
        end else begin
            case ({req_m0, req_m1})
                // conflict alternates the winner
                2'b11:   prio_q <= (prio_q == prio_m0) ? prio_m1 : prio_m0;
                // m0 alone hands the next conflict to m1
                2'b10:   prio_q <= prio_m1;
                2'b01:   prio_q <= prio_m0;
                default: prio_q <= prio_q;
            endcase
        end
    end

    // write pointer moves only on an accepted write
    // natural 2-bit wrap takes 3 back to 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
        end else if (wr_ok) begin
            wr_ptr_q <= wr_ptr_q + bank_id_t'(1);
        end
    end

    // one bank per direction at a time
    a_wr_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(bank_wr_en)
    ) else $error("more than one bank write enable");

    a_rd_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(bank_rd_en)
    ) else $error("more than one bank read enable");

    // both masters never read back the same cycle
    a_grant_excl: assert property (
        @(posedge clk) disable iff (rst) !(rd_grant_m0 && rd_grant_m1)
    ) else $error("read granted to both masters");

endmodule

`default_nettype wire

// File: rtl/read_return.sv
`timescale 1ns/100ps
`default_nettype none

// read data return
// one register stage after the bank pop
module read_return
    import four_bank_fifo_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire bank_mask_t                   bank_rd_en,
    input  wire data_t [num_banks-1:0]        bank_rd_data,
    input  wire logic                         rd_grant_m0,
    input  wire logic                         rd_grant_m1,
    output data_t                             data_out_m0,
    output data_t                             data_out_m1,
    output logic                              valid_m0,
    output logic                              valid_m1
);

    // which bank popped last cycle, and for whom
    bank_mask_t rd_mask_q;
    logic       grant_m0_q;
    logic       grant_m1_q;

    // byte from the bank read last cycle
    data_t sel_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_mask_q  <= '0;
            grant_m0_q <= 1'b0;
            grant_m1_q <= 1'b0;
        end else begin
            rd_mask_q  <= bank_rd_en;
            grant_m0_q <= rd_grant_m0;
            grant_m1_q <= rd_grant_m1;
        end
    end

    // and-or select, mask is one-hot or zero
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < num_banks; i++) begin
            sel_data |= bank_rd_data[i] & {data_w{rd_mask_q[i]}};
        end
    end

    // zero when this master had no read
    assign data_out_m0 = grant_m0_q ? sel_data : '0;
    assign data_out_m1 = grant_m1_q ? sel_data : '0;
    assign valid_m0    = grant_m0_q;
    assign valid_m1    = grant_m1_q;

    a_mask_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(rd_mask_q)
    ) else $error("read return mask not one-hot");

    // a bank popped exactly when some master was granted
    a_mask_matches_grant: assert property (
        @(posedge clk) disable iff (rst) (|rd_mask_q) == (grant_m0_q || grant_m1_q)
    ) else $error("read mask and grant disagree");

endmodule

`default_nettype wire

// File: rtl/four_bank_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// two-master shared buffer over four fifo banks
module four_bank_fifo
    import four_bank_fifo_pkg::*;
#(
    parameter int fifo_depth = 32
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     wr_en_m0,
    input  wire data_t    data_in_m0,
    input  wire logic     rd_en_m0,
    input  wire bank_id_t rd_id_m0,
    input  wire logic     wr_en_m1,
    input  wire data_t    data_in_m1,
    input  wire logic     rd_en_m1,
    input  wire bank_id_t rd_id_m1,
    output data_t         data_out_m0,
    output data_t         data_out_m1,
    output logic          valid_m0,
    output logic          valid_m1
);

    // per-bank strobes and flags
    bank_mask_t bank_wr_en;
    bank_mask_t bank_rd_en;
    bank_mask_t bank_full;
    bank_mask_t bank_empty;

    // shared write bus, gated by each bank's enable
    data_t wr_data;

    // bank outputs, one byte each
    data_t [num_banks-1:0] bank_rd_data;

    logic rd_grant_m0;
    logic rd_grant_m1;

    port_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .wr_en_m0    (wr_en_m0),
        .rd_en_m0    (rd_en_m0),
        .wr_en_m1    (wr_en_m1),
        .rd_en_m1    (rd_en_m1),
        .data_in_m0  (data_in_m0),
        .data_in_m1  (data_in_m1),
        .rd_id_m0    (rd_id_m0),
        .rd_id_m1    (rd_id_m1),
        .bank_full   (bank_full),
        .bank_empty  (bank_empty),
        .bank_wr_en  (bank_wr_en),
        .bank_rd_en  (bank_rd_en),
        .wr_data     (wr_data),
        .rd_grant_m0 (rd_grant_m0),
        .rd_grant_m1 (rd_grant_m1)
    );

    // identical banks
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        bank_fifo #(
            .fifo_depth (fifo_depth)
        ) u_bank (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (bank_wr_en[b]),
            .rd_en   (bank_rd_en[b]),
            .wr_data (wr_data),
            .rd_data (bank_rd_data[b]),
            .full    (bank_full[b]),
            .empty   (bank_empty[b])
        );
    end

    read_return u_return (
        .clk          (clk),
        .rst          (rst),
        .bank_rd_en   (bank_rd_en),
        .bank_rd_data (bank_rd_data),
        .rd_grant_m0  (rd_grant_m0),
        .rd_grant_m1  (rd_grant_m1),
        .data_out_m0  (data_out_m0),
        .data_out_m1  (data_out_m1),
        .valid_m0     (valid_m0),
        .valid_m1     (valid_m1)
    );

endmodule

`default_nettype wire

// File: dv/fifo_checker.sv
`timescale 1ns/100ps
`default_nettype none

// compares DUT outputs with the expected row
// sampled on the falling edge, well after the outputs settle
module fifo_checker
    import four_bank_fifo_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         check_en,
    input  wire logic [127:0] test_name,
    input  wire logic [31:0]  row_idx,
    input  wire logic         exp_valid_m0,
    input  wire data_t        exp_data_m0,
    input  wire logic         exp_valid_m1,
    input  wire data_t        exp_data_m1,
    input  wire logic         valid_m0,
    input  wire data_t        data_out_m0,
    input  wire logic         valid_m1,
    input  wire data_t        data_out_m1,
    output int                error_count,
    output int                check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // one field of one row
    task automatic compare(input string field, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %0s (row %0d) %0s: expected %h, actual %h",
                     test_name, row_idx, field, expected, actual);
        end
    endtask

    // valid and data of both masters each cycle
    always @(negedge clk) begin
        if (check_en) begin
            compare("valid_m0", data_t'(exp_valid_m0), data_t'(valid_m0));
            compare("data_out_m0", exp_data_m0, data_out_m0);
            compare("valid_m1", data_t'(exp_valid_m1), data_t'(valid_m1));
            compare("data_out_m1", exp_data_m1, data_out_m1);
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_four_bank_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module tb_four_bank_fifo
    import four_bank_fifo_pkg::*;
();

    localparam int depth = 32;
    localparam int period = 40;

    typedef logic [127:0] name_t;

    // stimulus for one cycle, expected outputs for the cycle after
    typedef struct packed {
        name_t    name;
        logic     wr_en_m0;
        data_t    data_m0;
        logic     rd_en_m0;
        bank_id_t rd_id_m0;
        logic     wr_en_m1;
        data_t    data_m1;
        logic     rd_en_m1;
        bank_id_t rd_id_m1;
        logic     exp_valid_m0;
        data_t    exp_data_m0;
        logic     exp_valid_m1;
        data_t    exp_data_m1;
    } row_t;

    logic     clk;
    logic     rst;
    logic     wr_en_m0;
    logic     rd_en_m0;
    logic     wr_en_m1;
    logic     rd_en_m1;
    data_t    data_in_m0;
    data_t    data_in_m1;
    bank_id_t rd_id_m0;
    bank_id_t rd_id_m1;
    data_t    data_out_m0;
    data_t    data_out_m1;
    logic     valid_m0;
    logic     valid_m1;

    // row under check
    logic        check_en;
    name_t       cur_name;
    logic [31:0] cur_idx;
    row_t        cur_row;
    int          error_count;
    int          check_count;

    row_t rows[$];
    bit   table_ready = 1'b0;

    // random payloads per test group
    data_t a_byte[4];
    data_t b_byte[4];
    data_t c_byte[8];
    data_t e_byte[5];
    data_t f_byte[4*depth];
    data_t g_byte;
    data_t h_byte;

    four_bank_fifo #(
        .fifo_depth (depth)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .wr_en_m0    (wr_en_m0),
        .data_in_m0  (data_in_m0),
        .rd_en_m0    (rd_en_m0),
        .rd_id_m0    (rd_id_m0),
        .wr_en_m1    (wr_en_m1),
        .data_in_m1  (data_in_m1),
        .rd_en_m1    (rd_en_m1),
        .rd_id_m1    (rd_id_m1),
        .data_out_m0 (data_out_m0),
        .data_out_m1 (data_out_m1),
        .valid_m0    (valid_m0),
        .valid_m1    (valid_m1)
    );

    fifo_checker u_checker (
        .clk          (clk),
        .check_en     (check_en),
        .test_name    (cur_name),
        .row_idx      (cur_idx),
        .exp_valid_m0 (cur_row.exp_valid_m0),
        .exp_data_m0  (cur_row.exp_data_m0),
        .exp_valid_m1 (cur_row.exp_valid_m1),
        .exp_data_m1  (cur_row.exp_data_m1),
        .valid_m0     (valid_m0),
        .data_out_m0  (data_out_m0),
        .valid_m1     (valid_m1),
        .data_out_m1  (data_out_m1),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(period/2) clk = ~clk;
    end

    function automatic data_t rand_byte();
        return data_t'($urandom);
    endfunction

    task automatic add_row(input name_t name,
                           input logic w0, input data_t d0, input logic r0, input bank_id_t id0,
                           input logic w1, input data_t d1, input logic r1, input bank_id_t id1,
                           input logic ev0, input data_t ed0, input logic ev1, input data_t ed1);
        rows.push_back('{name, w0, d0, r0, id0, w1, d1, r1, id1, ev0, ed0, ev1, ed1});
    endtask

    // lone write, no read comes back
    task automatic write_row(input name_t name, input bit m1, input data_t d);
        if (m1) add_row(name, 0, 0, 0, 0, 1, d, 0, 0, 0, 0, 0, 0);
        else add_row(name, 1, d, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    // lone read, result expected on the reader only
    task automatic read_row(input name_t name, input bit m1, input bank_id_t id,
                            input logic ev, input data_t ed);
        if (m1) add_row(name, 0, 0, 0, 0, 0, 0, 1, id, 0, 0, ev, ed);
        else add_row(name, 0, 0, 1, id, 0, 0, 0, 0, ev, ed, 0, 0);
    endtask

    task automatic drive_row(input row_t r);
        wr_en_m0   = r.wr_en_m0;
        data_in_m0 = r.data_m0;
        rd_en_m0   = r.rd_en_m0;
        rd_id_m0   = r.rd_id_m0;
        wr_en_m1   = r.wr_en_m1;
        data_in_m1 = r.data_m1;
        rd_en_m1   = r.rd_en_m1;
        rd_id_m1   = r.rd_id_m1;
    endtask

    task automatic build_table();
        // reset state, then a read of an empty bank
        add_row("reset_idle", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        read_row("rd_after_rst", 1, 3, 0, 0);
        // m0 wins first conflict, m1 the next
        add_row("conflict_m0", 1, a_byte[0], 0, 0, 1, b_byte[0], 0, 0, 0, 0, 0, 0);
        add_row("conflict_m1", 1, a_byte[1], 0, 0, 1, b_byte[1], 0, 0, 0, 0, 0, 0);
        // m0 alone hands priority to m1
        write_row("m0_alone", 0, a_byte[2]);
        add_row("conflict_after", 1, a_byte[3], 0, 0, 1, b_byte[3], 0, 0, 0, 0, 0, 0);
        // winners sit in banks 0 to 3
        read_row("arb_rd_b0", 0, 0, 1, a_byte[0]);
        read_row("arb_rd_b1", 0, 1, 1, b_byte[1]);
        read_row("arb_rd_b2", 0, 2, 1, a_byte[2]);
        read_row("m1_return", 1, 3, 1, b_byte[3]);
        // losers never stored
        for (int i = 0; i < 4; i++) read_row("loser_gone", 0, bank_id_t'(i), 0, 0);
        // round-robin placement, pointer back at bank 0
        for (int i = 0; i < 8; i++) write_row("rr_write", 0, c_byte[i]);
        for (int i = 0; i < 8; i++) read_row("rr_read", 0, bank_id_t'(i % 4), 1, c_byte[i]);
        // push and pop bank 0 in one cycle
        for (int i = 0; i < 4; i++) write_row("wr_rd_fill", 1, e_byte[i]);
        add_row("wr_rd_same", 0, 0, 0, 0, 1, e_byte[4], 1, 0, 0, 0, 1, e_byte[0]);
        for (int i = 0; i < 4; i++) begin
            read_row("wr_rd_drain", 1, bank_id_t'((i + 1) % 4), 1, e_byte[i + 1]);
        end
        // pointer now at bank 1, so bank 1 holds every fourth fill byte
        for (int i = 0; i < 4*depth; i++) write_row("fill", 0, f_byte[i]);
        write_row("full_drop", 0, g_byte);
        read_row("full_pop", 0, 1, 1, f_byte[0]);
        // held pointer puts this one in bank 1
        write_row("refill_same", 0, h_byte);
        for (int k = 1; k < depth; k++) read_row("full_drain", 0, 1, 1, f_byte[4*k]);
        read_row("full_last", 0, 1, 1, h_byte);
        read_row("full_empty", 0, 1, 0, 0);
    endtask

    initial begin
        int seed_ret;
        rst      = 1'b1;
        check_en = 1'b0;
        cur_name = '0;
        cur_idx  = '0;
        cur_row  = '0;
        drive_row('0);
        seed_ret = $urandom(32'h8bf6);
        for (int i = 0; i < 4; i++) begin
            a_byte[i] = rand_byte();
            b_byte[i] = rand_byte();
        end
        foreach (c_byte[i]) c_byte[i] = rand_byte();
        foreach (e_byte[i]) e_byte[i] = rand_byte();
        foreach (f_byte[i]) f_byte[i] = rand_byte();
        g_byte = rand_byte();
        h_byte = rand_byte();
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #5 rst = 1'b0;
        // row k driven while row k-1 is checked
        for (int k = 0; k <= rows.size(); k++) begin
            @(posedge clk);
            #5;
            if (k < rows.size()) drive_row(rows[k]);
            else drive_row('0);
            if (k > 0) begin
                cur_row  = rows[k-1];
                cur_name = rows[k-1].name;
                cur_idx  = k - 1;
                check_en = 1'b1;
            end
        end
        @(posedge clk);
        #5 check_en = 1'b0;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * period);
        $display("timeout: the table did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/four_bank_fifo_pkg.sv
rtl/bank_fifo.sv
rtl/port_arbiter.sv
rtl/read_return.sv
rtl/four_bank_fifo.sv
dv/fifo_checker.sv
dv/tb_four_bank_fifo.sv

// File: Bender.yml
package:
  name: four_bank_fifo

sources:
  - rtl/four_bank_fifo_pkg.sv
  - rtl/bank_fifo.sv
  - rtl/port_arbiter.sv
  - rtl/read_return.sv
  - rtl/four_bank_fifo.sv
  - target: test
    files:
      - dv/fifo_checker.sv
      - dv/tb_four_bank_fifo.sv
